//--- filelist.f
+incdir+source
source/videoPkg.sv
source/lineBufPkg.sv
source/lineBuffer.sv
source/fixLayer.sv
source/paletteMux.sv
source/neoB1Top.sv
verification/clockGen.sv
verification/neoB1_assertions.sv
verification/neoB1Tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= neoB1Tb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= filelist.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/neoB1Tb.sv
// Random test of the palette-address stage against a cycle model
// pa is checked on every falling edge, buffers are filled before the first read
`timescale 1ns/1ps
`include "neoB1_settings.svh"

module neoB1Tb;

	localparam int NUM_LINES = 8;
	// A line is about two buffer lengths, doubled plus fill lines for margin
	localparam int CYCLE_LIMIT = 4 * `LB_DEPTH * (NUM_LINES + 2) + 100;

	logic              CLK_1HB;
	logic              rst;
	logic              flip;
	logic              oddPix;
	logic              blank;
	lineBufPkg::lbCmdT renderCmd;
	lineBufPkg::lbCmdT displayCmd;
	videoPkg::fixInT   fixIn;
	logic              cpuStrobe;
	logic              cpuA23;
	logic              cpuA22;
	logic [11:0]       cpuAddr;
	videoPkg::palAddrT pa;

	// Model state, buffers ordered BL, BR, TL, TR
	logic [11:0] mMem [4][`LB_DEPTH];
	int          mAddr [4];
	logic [11:0] mRd [4];
	logic [7:0]  mFixReg;
	logic [3:0]  mPalReg;
	logic [11:0] mVideo;
	logic        mSel;

	integer seed;
	int     cycles = 0;
	int     checks = 0;
	int     errors = 0;
	int     fixShown = 0;
	int     cpuShown = 0;
	int     blankSeen = 0;

	clockGen clkGen (.CLK_1HB(CLK_1HB), .rst(rst));

	neoB1Top i_neoB1Top (
		.CLK_1HB   (CLK_1HB),
		.rst       (rst),
		.flip      (flip),
		.oddPix    (oddPix),
		.blank     (blank),
		.renderCmd (renderCmd),
		.displayCmd(displayCmd),
		.fixIn     (fixIn),
		.cpuStrobe (cpuStrobe),
		.cpuA23    (cpuA23),
		.cpuA22    (cpuA22),
		.cpuAddr   (cpuAddr),
		.pa        (pa)
	);

	// Run limit
	always @(posedge CLK_1HB) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic lineBufPkg::lbCmdT makeCmd(input lineBufPkg::lbOpT op,
		input logic [`LB_AW-1:0] addr, input logic [7:0] pal, input logic [3:0] color,
		input logic clear);
		lineBufPkg::lbCmdT c;
		c.op = op;
		c.loadAddr = addr;
		c.palette = pal;
		c.color = color;
		c.clearEn = clear;
		return c;
	endfunction

	// One rising edge of the model, inputs as they stood before the edge
	task automatic advanceModel();
		logic [3:0]        fixColor;
		lineBufPkg::lbCmdT cmd;
		if (rst) begin
			mAddr = '{default: 0};
			mRd = '{default: '0};
			mFixReg = '0;
			mPalReg = '0;
			mVideo = '0;
			mSel = 1'b0;
		end else begin
			// Priority blank, opaque fix, then display-pair sprite
			fixColor = oddPix ? mFixReg[7:4] : mFixReg[3:0];
			if (blank) begin
				mVideo = '0;
				blankSeen++;
			end else if (fixColor != 4'd0 && fixIn.enFix) begin
				mVideo = {4'd0, mPalReg, fixColor};
				fixShown++;
			end else begin
				mVideo = mRd[flip ? int'(oddPix) : 2 + int'(oddPix)];
			end
			if (cpuStrobe) begin
				mSel = (cpuA23 == `CPU_SEL_A23) && (cpuA22 == `CPU_SEL_A22);
			end
			if (fixIn.fixLoad) begin
				mFixReg = fixIn.fixData;
				mPalReg = fixIn.fixPal;
			end
			for (int b = 0; b < 4; b++) begin
				// Bottom pair renders while flip is 0
				cmd = ((b < 2) != flip) ? renderCmd : displayCmd;
				// Writes reach one side only
				if ((b < 2) != flip && cmd.op == lineBufPkg::LB_WRITE && b[0] != oddPix) begin
					cmd.op = lineBufPkg::LB_IDLE;
				end
				case (cmd.op)
					lineBufPkg::LB_LOAD: begin
						mAddr[b] = int'(cmd.loadAddr);
					end
					lineBufPkg::LB_WRITE: begin
						if (cmd.color != 4'd0) begin
							mMem[b][mAddr[b]] = {cmd.palette, cmd.color};
						end
						mAddr[b] = (mAddr[b] + 1) % `LB_DEPTH;
					end
					lineBufPkg::LB_READ: begin
						mRd[b] = mMem[b][mAddr[b]];
						if (cmd.clearEn) begin
							mMem[b][mAddr[b]] = '0;
						end
						mAddr[b] = (mAddr[b] + 1) % `LB_DEPTH;
					end
					default: begin
					end
				endcase
			end
		end
	endtask

	task automatic checkPa();
		logic [11:0] expected;
		// CPU address passes straight through
		expected = mSel ? cpuAddr : mVideo;
		checks++;
		if (mSel) begin
			cpuShown++;
		end
		if (pa !== expected) begin
			errors++;
			$display("Error: pa = %h, expected %h at cycle %0d", pa, expected, cycles);
		end
	endtask

	// Check mid-cycle, then advance on the rising edge
	task automatic tick();
		@(negedge CLK_1HB);
		checkPa();
		@(posedge CLK_1HB);
		advanceModel();
	endtask

	task automatic driveSideband();
		logic [31:0]     r;
		videoPkg::fixInT f;
		r = $random(seed);
		f.fixData = r[7:0];
		f.fixPal = r[11:8];
		f.fixLoad = (r[13:12] == 2'b00);
		f.enFix = r[14];
		fixIn <= f;
		blank <= (r[18:16] == 3'b000);
		// Rare strobes, one in four decodes matches
		cpuStrobe <= (r[23:19] == 5'd0);
		cpuA23 <= r[24];
		cpuA22 <= r[25];
		r = $random(seed);
		cpuAddr <= r[11:0];
	endtask

	// Render one line while the other pair is read twice
	task automatic runLine(input logic f, input logic fill);
		logic [31:0]       r;
		logic [3:0]        color;
		logic [`LB_AW-1:0] start;
		r = $random(seed);
		start = `LB_AW'(r[15:0] % `LB_DEPTH);
		flip <= f;
		renderCmd <= makeCmd(lineBufPkg::LB_LOAD, '0, 8'd0, 4'd0, 1'b0);
		displayCmd <= makeCmd(fill ? lineBufPkg::LB_IDLE : lineBufPkg::LB_LOAD,
			start, 8'd0, 4'd0, 1'b0);
		tick();
		for (int i = 0; i < 2 * `LB_DEPTH + 1; i++) begin
			r = $random(seed);
			color = r[7:4];
			// Fill leaves no entry undefined
			if (fill) begin
				color = color | 4'd1;
			end else if (r[3:2] == 2'b00) begin
				color = 4'd0;
			end
			oddPix <= fill ? i[0] : r[0];
			renderCmd <= makeCmd(lineBufPkg::LB_WRITE, '0, r[15:8], color, 1'b0);
			// First pass clears, second pass reads zeros
			if (fill) begin
				displayCmd <= makeCmd(lineBufPkg::LB_IDLE, '0, 8'd0, 4'd0, 1'b0);
			end else if (i == `LB_DEPTH) begin
				displayCmd <= makeCmd(lineBufPkg::LB_LOAD, start, 8'd0, 4'd0, 1'b0);
			end else begin
				displayCmd <= makeCmd(lineBufPkg::LB_READ, '0, 8'd0, 4'd0, i < `LB_DEPTH);
			end
			if (!fill) begin
				driveSideband();
			end
			tick();
		end
	endtask

	initial begin
		seed = 32'h23a1;
		flip <= 1'b0;
		oddPix <= 1'b0;
		blank <= 1'b0;
		renderCmd <= '0;
		displayCmd <= '0;
		fixIn <= '0;
		cpuStrobe <= 1'b0;
		cpuA23 <= 1'b0;
		cpuA22 <= 1'b0;
		cpuAddr <= '0;
		mAddr = '{default: 0};
		mRd = '{default: '0};
		mFixReg = '0;
		mPalReg = '0;
		mVideo = '0;
		mSel = 1'b0;
		tick();
		while (rst) begin
			tick();
		end
		runLine(1'b0, 1'b1);
		runLine(1'b1, 1'b1);
		for (int n = 0; n < NUM_LINES; n++) begin
			runLine(n[0], 1'b0);
		end
		renderCmd <= '0;
		displayCmd <= '0;
		repeat (3) tick();
		if (fixShown == 0 || cpuShown == 0 || blankSeen == 0) begin
			errors++;
			$display("Random stimulus never reached the fix, CPU or blank priority");
		end
		if (i_neoB1Top.i_paletteMux.busChecks.failures != 0) begin
			errors += i_neoB1Top.i_paletteMux.busChecks.failures;
			$display("Bound assertions failed %0d times",
				i_neoB1Top.i_paletteMux.busChecks.failures);
		end
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- verification/neoB1_assertions.sv
// Concurrent checks on the palette output stage, bound into paletteMux
// The decode check assumes rst is not asserted again during the run
`timescale 1ns/1ps
`include "neoB1_settings.svh"

module neoB1Assertions (
	input logic              CLK_1HB,
	input logic              rst,
	input logic              blank,
	input logic              cpuStrobe,
	input logic              cpuA23,
	input logic              cpuA22,
	input logic              cpuSel,
	input logic [11:0]       cpuAddr,
	input videoPkg::palAddrT videoAddr,
	input videoPkg::palAddrT pa
);

	int failures = 0;

	// Output register and CPU decode cleared by reset
	resetState: assert property (@(posedge CLK_1HB) rst |=> (videoAddr == '0 && !cpuSel))
		else begin
			failures++;
			$error("videoAddr or cpuSel not cleared after reset");
		end

	// Blanking zeroes the video register one cycle later
	blankZero: assert property (@(posedge CLK_1HB) blank |=> (videoAddr == '0))
		else begin
			failures++;
			$error("videoAddr not zero after blank");
		end

	// Matching strobe hands the bus to the CPU from the next cycle
	cpuOverride: assert property (@(posedge CLK_1HB) disable iff (rst)
		(cpuStrobe && cpuA23 == `CPU_SEL_A23 && cpuA22 == `CPU_SEL_A22)
			|=> (pa == cpuAddr))
		else begin
			failures++;
			$error("pa differs from cpuAddr after a matching strobe");
		end

	// Decode latched on each strobe
	cpuDecode: assert property (@(posedge CLK_1HB) disable iff (rst)
		cpuStrobe |=> (cpuSel == ($past(cpuA23) == `CPU_SEL_A23
			&& $past(cpuA22) == `CPU_SEL_A22)))
		else begin
			failures++;
			$error("cpuSel does not follow the address decode");
		end

endmodule

bind paletteMux neoB1Assertions busChecks (
	.CLK_1HB  (CLK_1HB),
	.rst      (rst),
	.blank    (blank),
	.cpuStrobe(cpuStrobe),
	.cpuA23   (cpuA23),
	.cpuA22   (cpuA22),
	.cpuSel   (cpuSel),
	.cpuAddr  (cpuAddr),
	.videoAddr(videoAddr),
	.pa       (pa)
);

//--- verification/clockGen.sv
// Testbench clock and reset source
// rst is released on a rising edge after RESET_CYCLES cycles
`timescale 1ns/1ps

module clockGen #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic CLK_1HB,
	output logic rst
);

	// Free-running clock, first rising edge at half a period
	initial begin
		CLK_1HB = 1'b0;
		forever begin
			#(PERIOD / 2) CLK_1HB = ~CLK_1HB;
		end
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK_1HB);
		rst <= 1'b0;
	end

endmodule

//--- source/neoB1Top.sv
// Palette-address stage top level
// Render writes go to one buffer of the render pair by oddPix, loads to both
// Display commands drive both buffers of the display pair
`timescale 1ns/1ps

module neoB1Top (
	input  logic              CLK_1HB,
	input  logic              rst,
	input  logic              flip,
	input  logic              oddPix,
	input  logic              blank,
	input  lineBufPkg::lbCmdT renderCmd,
	input  lineBufPkg::lbCmdT displayCmd,
	input  videoPkg::fixInT   fixIn,
	input  logic              cpuStrobe,
	input  logic              cpuA23,
	input  logic              cpuA22,
	input  logic [11:0]       cpuAddr,
	output videoPkg::palAddrT pa
);

	lineBufPkg::lbCmdT renderL;
	lineBufPkg::lbCmdT renderR;
	lineBufPkg::lbCmdT cmdBL;
	lineBufPkg::lbCmdT cmdBR;
	lineBufPkg::lbCmdT cmdTL;
	lineBufPkg::lbCmdT cmdTR;
	videoPkg::palAddrT outBL;
	videoPkg::palAddrT outBR;
	videoPkg::palAddrT outTL;
	videoPkg::palAddrT outTR;
	videoPkg::palAddrT fixAddr;
	logic              fixOpaque;

	// Mask writes meant for the other side of the pair
	always_comb begin
		renderL = renderCmd;
		renderR = renderCmd;
		if (renderCmd.op == lineBufPkg::LB_WRITE) begin
			if (oddPix) begin
				renderL.op = lineBufPkg::LB_IDLE;
			end else begin
				renderR.op = lineBufPkg::LB_IDLE;
			end
		end
	end

	// flip 0 renders bottom, shows top
	assign cmdBL = flip ? displayCmd : renderL;
	assign cmdBR = flip ? displayCmd : renderR;
	assign cmdTL = flip ? renderL : displayCmd;
	assign cmdTR = flip ? renderR : displayCmd;

	lineBuffer lbBL (.CLK_1HB(CLK_1HB), .rst(rst), .cmd(cmdBL), .rdData(outBL));
	lineBuffer lbBR (.CLK_1HB(CLK_1HB), .rst(rst), .cmd(cmdBR), .rdData(outBR));
	lineBuffer lbTL (.CLK_1HB(CLK_1HB), .rst(rst), .cmd(cmdTL), .rdData(outTL));
	lineBuffer lbTR (.CLK_1HB(CLK_1HB), .rst(rst), .cmd(cmdTR), .rdData(outTR));

	fixLayer i_fixLayer (
		.CLK_1HB  (CLK_1HB),
		.rst      (rst),
		.fixIn    (fixIn),
		.oddPix   (oddPix),
		.fixAddr  (fixAddr),
		.fixOpaque(fixOpaque)
	);

	paletteMux i_paletteMux (
		.CLK_1HB  (CLK_1HB),
		.rst      (rst),
		.flip     (flip),
		.oddPix   (oddPix),
		.blank    (blank),
		.bl       (outBL),
		.br       (outBR),
		.tl       (outTL),
		.tr       (outTR),
		.fixAddr  (fixAddr),
		.fixOpaque(fixOpaque),
		.cpuStrobe(cpuStrobe),
		.cpuA23   (cpuA23),
		.cpuA22   (cpuA22),
		.cpuAddr  (cpuAddr),
		.pa       (pa)
	);

endmodule

//--- source/paletteMux.sv
// Palette bus output stage
// Priority is CPU, then blank, then opaque fix, then sprite
// The CPU override is combinational from cpuAddr once the decode is latched
`timescale 1ns/1ps
`include "neoB1_settings.svh"

module paletteMux (
	input  logic              CLK_1HB,
	input  logic              rst,
	input  logic              flip,
	input  logic              oddPix,
	input  logic              blank,
	input  videoPkg::palAddrT bl,
	input  videoPkg::palAddrT br,
	input  videoPkg::palAddrT tl,
	input  videoPkg::palAddrT tr,
	input  videoPkg::palAddrT fixAddr,
	input  logic              fixOpaque,
	input  logic              cpuStrobe,
	input  logic              cpuA23,
	input  logic              cpuA22,
	input  logic [11:0]       cpuAddr,
	output videoPkg::palAddrT pa
);

	videoPkg::palAddrT spriteAddr;
	videoPkg::palAddrT videoNext;
	videoPkg::palAddrT videoAddr;
	logic              cpuHit;
	logic              cpuSel;

	// Display pair is the one not being rendered
	always_comb begin
		case ({flip, oddPix})
			2'b00:   spriteAddr = tl;
			2'b01:   spriteAddr = tr;
			2'b10:   spriteAddr = bl;
			default: spriteAddr = br;
		endcase
	end

	// Blank wins, then fix over sprites
	assign videoNext = blank ? '0 : (fixOpaque ? fixAddr : spriteAddr);

	// Palette window decode
	assign cpuHit = (cpuA23 == `CPU_SEL_A23) && (cpuA22 == `CPU_SEL_A22);

	always_ff @(posedge CLK_1HB) begin
		if (rst) begin
			videoAddr <= '0;
			cpuSel <= 1'b0;
		end else begin
			videoAddr <= videoNext;
			// Decode held between strobes
			if (cpuStrobe) begin
				cpuSel <= cpuHit;
			end
		end
	end

	// CPU owns the bus while selected
	assign pa = cpuSel ? videoPkg::palAddrT'(cpuAddr) : videoAddr;

endmodule

//--- source/fixLayer.sv
// Fix layer pixel path, two pixels per load
// Colour select by oddPix is combinational; enFix is used live
`timescale 1ns/1ps

module fixLayer (
	input  logic              CLK_1HB,
	input  logic              rst,
	input  videoPkg::fixInT   fixIn,
	input  logic              oddPix,
	output videoPkg::palAddrT fixAddr,
	output logic              fixOpaque
);

	// Two-pixel register
	logic [7:0] fixReg;
	// Fix palette register
	logic [3:0] palReg;
	videoPkg::colorT fixColor;

	// Both registers load on the same strobe
	always_ff @(posedge CLK_1HB) begin
		if (rst) begin
			fixReg <= '0;
			palReg <= '0;
		end else if (fixIn.fixLoad) begin
			fixReg <= fixIn.fixData;
			palReg <= fixIn.fixPal;
		end
	end

	// Odd pixel in the upper nibble
	assign fixColor = oddPix ? fixReg[7:4] : fixReg[3:0];

	// Fix palettes live in the first 16 only
	assign fixAddr.palette = {4'b0000, palReg};
	assign fixAddr.color = fixColor;

	// Opaque only when enabled and not colour 0
	assign fixOpaque = (fixColor != '0) && fixIn.enFix;

endmodule

//--- source/lineBuffer.sv
// One sprite line buffer, LB_DEPTH entries of one palette address each
// loadAddr must stay below LB_DEPTH; the counter wraps at the last entry
// Memory contents are undefined until written
`timescale 1ns/1ps
`include "neoB1_settings.svh"

module lineBuffer (
	input  logic              CLK_1HB,
	input  logic              rst,
	input  lineBufPkg::lbCmdT cmd,
	output videoPkg::palAddrT rdData
);

	localparam logic [`LB_AW-1:0] LAST_ADDR = `LB_AW'(`LB_DEPTH - 1);

	// Pixel storage
	videoPkg::palAddrT mem [`LB_DEPTH];

	// Auto-incrementing address counter
	logic [`LB_AW-1:0] addr;
	logic [`LB_AW-1:0] addrNext;

	// Single RAM write port
	logic              wrEn;
	videoPkg::palAddrT wrData;

	// Wrap back to entry 0 after the last one
	assign addrNext = (addr == LAST_ADDR) ? '0 : addr + 1'b1;

	// Write port source
	always_comb begin
		wrEn = 1'b0;
		wrData = '0;
		case (cmd.op)
			lineBufPkg::LB_WRITE: begin
				// Transparent pixels leave lower sprites intact
				wrEn = (cmd.color != '0);
				wrData.palette = cmd.palette;
				wrData.color = cmd.color;
			end
			lineBufPkg::LB_READ: begin
				// Clear behind the read, data stays zero
				wrEn = cmd.clearEn;
			end
			default: begin
				wrEn = 1'b0;
			end
		endcase
	end

	always_ff @(posedge CLK_1HB) begin
		if (wrEn) begin
			mem[addr] <= wrData;
		end
	end

	// Counter and read register
	always_ff @(posedge CLK_1HB) begin
		if (rst) begin
			addr <= '0;
			rdData <= '0;
		end else begin
			case (cmd.op)
				lineBufPkg::LB_LOAD: begin
					addr <= cmd.loadAddr;
				end
				lineBufPkg::LB_WRITE: begin
					// Step even on a skipped pixel
					addr <= addrNext;
				end
				lineBufPkg::LB_READ: begin
					// Old word out, clear lands on the same edge
					rdData <= mem[addr];
					addr <= addrNext;
				end
				default: begin
					addr <= addr;
				end
			endcase
		end
	end

endmodule

//--- source/lineBufPkg.sv
// Line buffer command types
// Needs videoPkg compiled first and the settings header on the include path
`include "neoB1_settings.svh"

package lineBufPkg;

	// Line buffer operations
	typedef enum logic [1:0] {
		LB_IDLE  = 2'd0,
		LB_LOAD  = 2'd1,
		LB_WRITE = 2'd2,
		LB_READ  = 2'd3
	} lbOpT;

	// One command per cycle to a buffer
	typedef struct packed {
		lbOpT              op;
		// Start address for LB_LOAD
		logic [`LB_AW-1:0] loadAddr;
		// Sprite palette for LB_WRITE
		logic [7:0]        palette;
		videoPkg::colorT   color;
		// Clear entry on LB_READ
		logic              clearEn;
	} lbCmdT;

endpackage

//--- source/videoPkg.sv
// Pixel and palette-address types shared by the video datapath
// Colour 0 is transparent everywhere in the design
package videoPkg;

	// 4-bit colour index inside one palette
	typedef logic [3:0] colorT;

	// Palette RAM address
	// Palette number in the upper byte, colour in the low nibble
	typedef struct packed {
		logic [7:0] palette;
		colorT      color;
	} palAddrT;

	// Fix layer input bundle
	typedef struct packed {
		// Two pixels, odd one in the upper nibble
		logic [7:0] fixData;
		// Fix palette number, only 16 available
		logic [3:0] fixPal;
		// Load strobe for pixels and palette
		logic       fixLoad;
		// Fix layer enable, gates opacity
		logic       enFix;
	} fixInT;

endpackage

//--- source/neoB1_settings.svh
// Shared sizing and decode constants for the palette-address stage
// LB_DEPTH must not exceed 2**LB_AW
`ifndef NEOB1_SETTINGS_SVH
`define NEOB1_SETTINGS_SVH

// Entries per line buffer, half of a 384-pixel line
`define LB_DEPTH 192

// Address counter width of one line buffer
`define LB_AW 8

// CPU palette window decode on the two top address bits
// Palette RAM sits where A23 is low and A22 is high
`define CPU_SEL_A23 1'b0
`define CPU_SEL_A22 1'b1

`endif
